// ==== logic/wg_defines.svh ====
`ifndef WG_DEFINES_SVH
`define WG_DEFINES_SVH

// Bus field widths
`define WG_ID_WIDTH 4
`define WG_ADDR_WIDTH 32

// Budgets and phase counters share one width
`define WG_CNT_WIDTH 8

// Outstanding writes tracked at once
`define WG_NUM_SLOTS 4
`define WG_SLOT_IDX_WIDTH 2

`endif

// ==== logic/wg_pkg.sv ====
package wg_pkg;

  `include "wg_defines.svh"

  typedef logic [`WG_ID_WIDTH-1:0]       id_t;
  typedef logic [`WG_ADDR_WIDTH-1:0]     addr_t;
  typedef logic [`WG_CNT_WIDTH-1:0]      cnt_t;
  typedef logic [`WG_SLOT_IDX_WIDTH-1:0] slot_idx_t;

  // Phase of one tracked write
  typedef enum logic [1:0] {
    SLOT_FREE,
    SLOT_WAIT_DATA,
    SLOT_WAIT_RESP
  } slot_state_e;

  // Lower value wins when several faults hit in one cycle
  typedef enum logic [2:0] {
    FAULT_NONE,
    FAULT_ADDR_STALL,
    FAULT_DATA_TIMEOUT,
    FAULT_RESP_TIMEOUT,
    FAULT_ID_MISMATCH
  } fault_cause_e;

endpackage

// ==== logic/wg_event_if.sv ====
`timescale 1ns/100ps

interface wg_event_if import wg_pkg::*; ();

  // AW channel
  logic  aw_xfer;
  id_t   aw_id;
  addr_t aw_addr;
  logic  aw_stall;

  // W channel, w_last only set together with w_xfer
  logic  w_xfer;
  logic  w_last;

  // B channel
  logic  b_xfer;
  id_t   b_id;

  modport decode_mp (
    output aw_xfer, aw_id, aw_addr, aw_stall, w_xfer, w_last, b_xfer, b_id
  );

  modport execute_mp (
    input  aw_xfer, aw_id, aw_addr, aw_stall, w_xfer, w_last, b_xfer, b_id
  );

endinterface

// ==== logic/wg_status_if.sv ====
`timescale 1ns/100ps

interface wg_status_if import wg_pkg::*; ();

  // Single-cycle fault report
  logic         fault_valid;
  fault_cause_e fault_cause;
  id_t          fault_id;
  addr_t        fault_addr;

  // All slots busy
  logic         table_full;

  modport execute_mp (
    output fault_valid, fault_cause, fault_id, fault_addr, table_full
  );

  modport result_mp (
    input  fault_valid, fault_cause, fault_id, fault_addr, table_full
  );

endinterface

// ==== logic/wg_decode.sv ====
`timescale 1ns/100ps

module wg_decode import wg_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          slv_aw_valid_i,
  input  logic          slv_aw_ready_i,
  input  id_t           aw_id_i,
  input  addr_t         aw_addr_i,
  input  logic          slv_w_valid_i,
  input  logic          slv_w_ready_i,
  input  logic          w_last_i,
  input  logic          mst_b_valid_i,
  input  logic          mst_b_ready_i,
  input  id_t           b_id_i,
  wg_event_if.decode_mp ev
);

  // Handshakes seen on the gated side of the guard
  assign ev.aw_xfer  = slv_aw_valid_i && slv_aw_ready_i;
  assign ev.aw_stall = slv_aw_valid_i && !slv_aw_ready_i;
  assign ev.aw_id    = aw_id_i;
  assign ev.aw_addr  = aw_addr_i;

  assign ev.w_xfer   = slv_w_valid_i && slv_w_ready_i;
  assign ev.w_last   = ev.w_xfer && w_last_i;

  assign ev.b_xfer   = mst_b_valid_i && mst_b_ready_i;
  assign ev.b_id     = b_id_i;

  // A presented last beat is held until the slave takes it, so a burst
  // never closes without its last transfer
  a_w_last_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    slv_w_valid_i && w_last_i && !slv_w_ready_i
      |=> slv_w_valid_i && w_last_i
  ) else $error("W last dropped before its transfer");

endmodule

// ==== logic/wg_execute.sv ====
`timescale 1ns/100ps

`include "wg_defines.svh"

module wg_execute import wg_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            guard_ena_i,
  input  cnt_t            budget_addr_i,
  input  cnt_t            budget_data_i,
  input  cnt_t            budget_resp_i,
  wg_event_if.execute_mp  ev,
  wg_status_if.execute_mp st
);

  // Slot table
  slot_state_e slot_state_q [`WG_NUM_SLOTS];
  id_t         slot_id_q    [`WG_NUM_SLOTS];
  addr_t       slot_addr_q  [`WG_NUM_SLOTS];
  cnt_t        slot_cnt_q   [`WG_NUM_SLOTS];

  // Data-order queue of slot indices, W data follows AW order
  slot_idx_t                   q_mem [`WG_NUM_SLOTS];
  slot_idx_t                   q_wr_ptr_q;
  slot_idx_t                   q_rd_ptr_q;
  logic [`WG_SLOT_IDX_WIDTH:0] q_count_q;

  cnt_t stall_cnt_q;

  logic [`WG_NUM_SLOTS-1:0] slot_free;
  slot_idx_t                free_idx;
  logic                     b_hit;
  slot_idx_t                b_idx;
  logic                     data_late;
  slot_idx_t                data_idx;
  logic                     resp_late;
  slot_idx_t                resp_idx;
  logic                     alloc;
  logic                     retire;
  slot_idx_t                ret_idx;
  logic                     addr_late;
  logic                     id_mismatch;
  logic                     flush;

  // Searches run from the top so the lowest index is kept
  always_comb begin
    free_idx  = '0;
    b_hit     = 1'b0;
    b_idx     = '0;
    data_late = 1'b0;
    data_idx  = '0;
    resp_late = 1'b0;
    resp_idx  = '0;
    for (int i = `WG_NUM_SLOTS - 1; i >= 0; i--) begin
      slot_free[i] = (slot_state_q[i] == SLOT_FREE);
      if (slot_free[i]) begin
        free_idx = slot_idx_t'(i);
      end
      if (slot_state_q[i] == SLOT_WAIT_RESP && slot_id_q[i] == ev.b_id) begin
        b_hit = 1'b1;
        b_idx = slot_idx_t'(i);
      end
      if (slot_state_q[i] == SLOT_WAIT_DATA && slot_cnt_q[i] == budget_data_i) begin
        data_late = 1'b1;
        data_idx  = slot_idx_t'(i);
      end
      if (slot_state_q[i] == SLOT_WAIT_RESP && slot_cnt_q[i] == budget_resp_i) begin
        resp_late = 1'b1;
        resp_idx  = slot_idx_t'(i);
      end
    end
  end

  assign st.table_full = ~|slot_free;

  assign alloc       = ev.aw_xfer && guard_ena_i;
  assign retire      = ev.w_last && (q_count_q != '0);
  assign ret_idx     = q_mem[q_rd_ptr_q];
  assign addr_late   = ev.aw_stall && (stall_cnt_q == budget_addr_i);
  assign id_mismatch = ev.b_xfer && !b_hit;

  // Fault selection by cause priority
  always_comb begin
    st.fault_cause = FAULT_NONE;
    st.fault_id    = '0;
    st.fault_addr  = '0;
    if (addr_late) begin
      st.fault_cause = FAULT_ADDR_STALL;
      st.fault_id    = ev.aw_id;
      st.fault_addr  = ev.aw_addr;
    end else if (data_late) begin
      st.fault_cause = FAULT_DATA_TIMEOUT;
      st.fault_id    = slot_id_q[data_idx];
      st.fault_addr  = slot_addr_q[data_idx];
    end else if (resp_late) begin
      st.fault_cause = FAULT_RESP_TIMEOUT;
      st.fault_id    = slot_id_q[resp_idx];
      st.fault_addr  = slot_addr_q[resp_idx];
    end else if (id_mismatch) begin
      st.fault_cause = FAULT_ID_MISMATCH;
      st.fault_id    = ev.b_id;
    end
  end

  assign st.fault_valid = guard_ena_i && (st.fault_cause != FAULT_NONE);

  // Disabled or faulted, everything goes back to idle
  assign flush = !guard_ena_i || st.fault_valid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `WG_NUM_SLOTS; i++) begin
        slot_state_q[i] <= SLOT_FREE;
        slot_cnt_q[i]   <= '0;
      end
    end else if (flush) begin
      for (int i = 0; i < `WG_NUM_SLOTS; i++) begin
        slot_state_q[i] <= SLOT_FREE;
        slot_cnt_q[i]   <= '0;
      end
    end else begin
      for (int i = 0; i < `WG_NUM_SLOTS; i++) begin
        if (alloc && free_idx == slot_idx_t'(i)) begin
          slot_state_q[i] <= SLOT_WAIT_DATA;
          slot_cnt_q[i]   <= '0;
        end else if (retire && ret_idx == slot_idx_t'(i)) begin
          slot_state_q[i] <= SLOT_WAIT_RESP;
          slot_cnt_q[i]   <= '0;
        end else if (ev.b_xfer && b_hit && b_idx == slot_idx_t'(i)) begin
          slot_state_q[i] <= SLOT_FREE;
          slot_cnt_q[i]   <= '0;
        end else if (slot_state_q[i] != SLOT_FREE) begin
          slot_cnt_q[i] <= slot_cnt_q[i] + 1'b1;
        end
      end
    end
  end

  // Recorded ID, address and queue entries
  always_ff @(posedge clk_i) begin
    if (alloc) begin
      slot_id_q[free_idx]   <= ev.aw_id;
      slot_addr_q[free_idx] <= ev.aw_addr;
      q_mem[q_wr_ptr_q]     <= free_idx;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      q_wr_ptr_q  <= '0;
      q_rd_ptr_q  <= '0;
      q_count_q   <= '0;
      stall_cnt_q <= '0;
    end else if (flush) begin
      q_wr_ptr_q  <= '0;
      q_rd_ptr_q  <= '0;
      q_count_q   <= '0;
      stall_cnt_q <= '0;
    end else begin
      if (alloc) begin
        q_wr_ptr_q <= q_wr_ptr_q + 1'b1;
      end
      if (retire) begin
        q_rd_ptr_q <= q_rd_ptr_q + 1'b1;
      end
      q_count_q <= q_count_q + alloc - retire;
      // Consecutive stall cycles only
      stall_cnt_q <= ev.aw_stall ? stall_cnt_q + 1'b1 : '0;
    end
  end

  // Result must hold AW back once the table fills
  a_no_alloc_full: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ev.aw_xfer |-> !st.table_full
  ) else $error("AW accepted with a full slot table");

endmodule

// ==== logic/wg_result.sv ====
`timescale 1ns/100ps

module wg_result import wg_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              guard_ena_i,
  input  logic              clear_i,
  // Master side
  input  logic              mst_aw_valid_i,
  input  id_t               mst_aw_id_i,
  input  addr_t             mst_aw_addr_i,
  input  logic              mst_w_valid_i,
  input  logic              mst_w_last_i,
  input  logic              mst_b_ready_i,
  output logic              mst_aw_ready_o,
  output logic              mst_w_ready_o,
  output logic              mst_b_valid_o,
  output id_t               mst_b_id_o,
  // Slave side
  input  logic              slv_aw_ready_i,
  input  logic              slv_w_ready_i,
  input  logic              slv_b_valid_i,
  input  id_t               slv_b_id_i,
  output logic              slv_aw_valid_o,
  output id_t               slv_aw_id_o,
  output addr_t             slv_aw_addr_o,
  output logic              slv_w_valid_o,
  output logic              slv_w_last_o,
  output logic              slv_b_ready_o,
  // Status and fault report
  wg_status_if.result_mp    st,
  output logic              reset_req_o,
  output logic              irq_o,
  output fault_cause_e      fault_cause_o,
  output id_t               fault_id_o,
  output addr_t             fault_addr_o
);

  logic latched_q;
  logic irq_q;
  logic blocked;
  logic aw_hold;

  assign blocked = guard_ena_i && latched_q;
  assign aw_hold = guard_ena_i && st.table_full;

  // While blocked the master drains freely and the slave sees nothing
  assign slv_aw_valid_o = mst_aw_valid_i && !blocked && !aw_hold;
  assign mst_aw_ready_o = blocked || (slv_aw_ready_i && !aw_hold);
  assign slv_w_valid_o  = mst_w_valid_i && !blocked;
  assign mst_w_ready_o  = slv_w_ready_i || blocked;
  assign mst_b_valid_o  = slv_b_valid_i && !blocked;
  assign slv_b_ready_o  = mst_b_ready_i || blocked;

  assign slv_aw_id_o   = mst_aw_id_i;
  assign slv_aw_addr_o = mst_aw_addr_i;
  assign slv_w_last_o  = mst_w_last_i;
  assign mst_b_id_o    = slv_b_id_i;

  // First fault is kept until clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      latched_q     <= 1'b0;
      irq_q         <= 1'b0;
      fault_cause_o <= FAULT_NONE;
      fault_id_o    <= '0;
      fault_addr_o  <= '0;
    end else if (clear_i) begin
      latched_q     <= 1'b0;
      irq_q         <= 1'b0;
      fault_cause_o <= FAULT_NONE;
      fault_id_o    <= '0;
      fault_addr_o  <= '0;
    end else if (st.fault_valid && !latched_q) begin
      latched_q     <= 1'b1;
      irq_q         <= 1'b1;
      fault_cause_o <= st.fault_cause;
      fault_id_o    <= st.fault_id;
      fault_addr_o  <= st.fault_addr;
    end else begin
      irq_q <= 1'b0;
    end
  end

  assign reset_req_o = latched_q;
  assign irq_o       = irq_q;

  a_irq_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    irq_o |=> !irq_o
  ) else $error("Interrupt held for more than one cycle");

endmodule

// ==== logic/write_guard.sv ====
`timescale 1ns/100ps

module write_guard import wg_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         guard_ena_i,
  input  logic         clear_i,
  input  cnt_t         budget_addr_i,
  input  cnt_t         budget_data_i,
  input  cnt_t         budget_resp_i,
  // Master side
  input  logic         mst_aw_valid_i,
  input  id_t          mst_aw_id_i,
  input  addr_t        mst_aw_addr_i,
  input  logic         mst_w_valid_i,
  input  logic         mst_w_last_i,
  input  logic         mst_b_ready_i,
  output logic         mst_aw_ready_o,
  output logic         mst_w_ready_o,
  output logic         mst_b_valid_o,
  output id_t          mst_b_id_o,
  // Slave side
  output logic         slv_aw_valid_o,
  output id_t          slv_aw_id_o,
  output addr_t        slv_aw_addr_o,
  output logic         slv_w_valid_o,
  output logic         slv_w_last_o,
  output logic         slv_b_ready_o,
  input  logic         slv_aw_ready_i,
  input  logic         slv_w_ready_i,
  input  logic         slv_b_valid_i,
  input  id_t          slv_b_id_i,
  // Fault report
  output logic         reset_req_o,
  output logic         irq_o,
  output fault_cause_e fault_cause_o,
  output id_t          fault_id_o,
  output addr_t        fault_addr_o
);

  wg_event_if  ev_if ();
  wg_status_if st_if ();

  // Decode watches the gated handshakes, not the raw inputs
  wg_decode wg_decode_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_aw_valid_i (slv_aw_valid_o),
    .slv_aw_ready_i (slv_aw_ready_i),
    .aw_id_i        (mst_aw_id_i),
    .aw_addr_i      (mst_aw_addr_i),
    .slv_w_valid_i  (slv_w_valid_o),
    .slv_w_ready_i  (slv_w_ready_i),
    .w_last_i       (mst_w_last_i),
    .mst_b_valid_i  (mst_b_valid_o),
    .mst_b_ready_i  (mst_b_ready_i),
    .b_id_i         (slv_b_id_i),
    .ev             (ev_if.decode_mp)
  );

  wg_execute wg_execute_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .guard_ena_i   (guard_ena_i),
    .budget_addr_i (budget_addr_i),
    .budget_data_i (budget_data_i),
    .budget_resp_i (budget_resp_i),
    .ev            (ev_if.execute_mp),
    .st            (st_if.execute_mp)
  );

  wg_result wg_result_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .guard_ena_i    (guard_ena_i),
    .clear_i        (clear_i),
    .mst_aw_valid_i (mst_aw_valid_i),
    .mst_aw_id_i    (mst_aw_id_i),
    .mst_aw_addr_i  (mst_aw_addr_i),
    .mst_w_valid_i  (mst_w_valid_i),
    .mst_w_last_i   (mst_w_last_i),
    .mst_b_ready_i  (mst_b_ready_i),
    .mst_aw_ready_o (mst_aw_ready_o),
    .mst_w_ready_o  (mst_w_ready_o),
    .mst_b_valid_o  (mst_b_valid_o),
    .mst_b_id_o     (mst_b_id_o),
    .slv_aw_ready_i (slv_aw_ready_i),
    .slv_w_ready_i  (slv_w_ready_i),
    .slv_b_valid_i  (slv_b_valid_i),
    .slv_b_id_i     (slv_b_id_i),
    .slv_aw_valid_o (slv_aw_valid_o),
    .slv_aw_id_o    (slv_aw_id_o),
    .slv_aw_addr_o  (slv_aw_addr_o),
    .slv_w_valid_o  (slv_w_valid_o),
    .slv_w_last_o   (slv_w_last_o),
    .slv_b_ready_o  (slv_b_ready_o),
    .st             (st_if.result_mp),
    .reset_req_o    (reset_req_o),
    .irq_o          (irq_o),
    .fault_cause_o  (fault_cause_o),
    .fault_id_o     (fault_id_o),
    .fault_addr_o   (fault_addr_o)
  );

endmodule

// ==== sim/tb_write_guard.sv ====
`timescale 1ns/100ps

module tb_write_guard import wg_pkg::*; ();

  localparam int TIMEOUT  = 200;
  localparam int NUM_ROWS = 8;

  logic         clk_i;
  logic         rst_ni;
  logic         guard_ena_i;
  logic         clear_i;
  cnt_t         budget_addr_i;
  cnt_t         budget_data_i;
  cnt_t         budget_resp_i;
  logic         mst_aw_valid_i;
  id_t          mst_aw_id_i;
  addr_t        mst_aw_addr_i;
  logic         mst_w_valid_i;
  logic         mst_w_last_i;
  logic         mst_b_ready_i;
  logic         mst_aw_ready_o;
  logic         mst_w_ready_o;
  logic         mst_b_valid_o;
  id_t          mst_b_id_o;
  logic         slv_aw_valid_o;
  id_t          slv_aw_id_o;
  addr_t        slv_aw_addr_o;
  logic         slv_w_valid_o;
  logic         slv_w_last_o;
  logic         slv_b_ready_o;
  logic         slv_aw_ready_i;
  logic         slv_w_ready_i;
  logic         slv_b_valid_i;
  id_t          slv_b_id_i;
  logic         reset_req_o;
  logic         irq_o;
  fault_cause_e fault_cause_o;
  id_t          fault_id_o;
  addr_t        fault_addr_o;

  // Test table, one entry per row in each array
  string        row_name  [NUM_ROWS];
  id_t          row_aw_id [NUM_ROWS];
  id_t          row_b_id  [NUM_ROWS];
  int           row_aw_dly[NUM_ROWS];
  int           row_w_dly [NUM_ROWS];
  int           row_b_dly [NUM_ROWS];
  cnt_t         row_bud_a [NUM_ROWS];
  cnt_t         row_bud_d [NUM_ROWS];
  cnt_t         row_bud_r [NUM_ROWS];
  logic         row_ena   [NUM_ROWS];
  fault_cause_e row_cause [NUM_ROWS];

  string cur_name;
  int    errors      = 0;
  int    tests       = 0;
  int    irq_cycles  = 0;
  int    leak_cycles = 0;
  int    early_aw    = 0;
  bit    aw_watch    = 0;

  write_guard write_guard_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Observers sampled mid-cycle, away from the driving edge
  always @(negedge clk_i) begin
    if (irq_o) irq_cycles++;
    if (reset_req_o && (slv_aw_valid_o || slv_w_valid_o || mst_b_valid_o)) leak_cycles++;
    if (aw_watch && mst_aw_ready_o) early_aw++;
  end

  task automatic compare(input string what, input logic [31:0] exp_v,
                         input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("** Error %s %s: expected 0x%0h, actual 0x%0h", cur_name, what, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Test %s gave up after %0d cycles waiting for %s", cur_name, TIMEOUT, what);
    errors++;
  endtask

  task automatic set_row(input int i, input string name, input id_t aw_id, input id_t b_id,
                         input int aw_dly, input int w_dly, input int b_dly,
                         input cnt_t ba, input cnt_t bd, input cnt_t br,
                         input logic ena, input fault_cause_e cause);
    row_name[i]   = name;
    row_aw_id[i]  = aw_id;
    row_b_id[i]   = b_id;
    row_aw_dly[i] = aw_dly;
    row_w_dly[i]  = w_dly;
    row_b_dly[i]  = b_dly;
    row_bud_a[i]  = ba;
    row_bud_d[i]  = bd;
    row_bud_r[i]  = br;
    row_ena[i]    = ena;
    row_cause[i]  = cause;
  endtask

  // Delays sit well clear of the budgets
  task automatic fill_table();
    set_row(0, "good_write",   4'd3,  4'd3,  1,  2,  2,  8,  8,  8,  1, FAULT_NONE);
    set_row(1, "addr_stall",   4'd5,  4'd5,  12, 1,  1,  6,  30, 30, 1, FAULT_ADDR_STALL);
    set_row(2, "after_clear",  4'd6,  4'd6,  0,  1,  1,  8,  8,  8,  1, FAULT_NONE);
    set_row(3, "data_timeout", 4'd9,  4'd9,  1,  15, 1,  20, 6,  20, 1, FAULT_DATA_TIMEOUT);
    set_row(4, "resp_timeout", 4'd10, 4'd10, 1,  1,  15, 20, 20, 6,  1, FAULT_RESP_TIMEOUT);
    set_row(5, "id_mismatch",  4'd2,  4'd7,  1,  1,  2,  20, 20, 20, 1, FAULT_ID_MISMATCH);
    set_row(6, "bypass",       4'd12, 4'd12, 12, 15, 15, 4,  4,  4,  0, FAULT_NONE);
    set_row(7, "good_again",   4'd1,  4'd1,  2,  2,  2,  8,  8,  8,  1, FAULT_NONE);
  endtask

  // Master AW with the slave holding ready low for dly cycles
  task automatic send_aw(input id_t id, input addr_t addr, input int dly, output bit ok);
    int n;
    bit hs;
    n  = 0;
    hs = 0;
    ok = 1;
    @(posedge clk_i);
    mst_aw_valid_i <= 1'b1;
    mst_aw_id_i    <= id;
    mst_aw_addr_i  <= addr;
    slv_aw_ready_i <= (dly == 0);
    while (!hs && ok) begin
      @(negedge clk_i);
      hs = mst_aw_ready_o;
      // The slave must see the master's ID and address unchanged
      if (slv_aw_valid_o) begin
        compare("slv_aw_id_o", id, slv_aw_id_o);
        compare("slv_aw_addr_o", addr, slv_aw_addr_o);
      end
      @(posedge clk_i);
      n++;
      if (!hs && n >= TIMEOUT) begin
        report_timeout("AW ready");
        ok = 0;
      end else if (!hs && n >= dly) begin
        slv_aw_ready_i <= 1'b1;
      end
    end
    mst_aw_valid_i <= 1'b0;
    slv_aw_ready_i <= 1'b0;
  endtask

  task automatic send_w(input int dly, output bit ok, output bit slave_got);
    int n;
    bit hs;
    n         = 0;
    hs        = 0;
    ok        = 1;
    slave_got = 0;
    repeat (dly) @(posedge clk_i);
    mst_w_valid_i <= 1'b1;
    mst_w_last_i  <= 1'b1;
    while (!hs && ok) begin
      @(negedge clk_i);
      hs        = mst_w_ready_o;
      slave_got = slv_w_valid_o;
      if (slv_w_valid_o) begin
        compare("slv_w_last_o", 1, slv_w_last_o);
      end
      @(posedge clk_i);
      n++;
      if (!hs && n >= TIMEOUT) begin
        report_timeout("W ready");
        ok = 0;
      end
    end
    mst_w_valid_i <= 1'b0;
    mst_w_last_i  <= 1'b0;
  endtask

  // Slave answers with B after dly cycles
  task automatic send_b(input id_t id, input int dly, output bit ok,
                        output bit seen, output id_t seen_id);
    int n;
    bit hs;
    n  = 0;
    hs = 0;
    ok = 1;
    repeat (dly) @(posedge clk_i);
    slv_b_valid_i <= 1'b1;
    slv_b_id_i    <= id;
    while (!hs && ok) begin
      @(negedge clk_i);
      hs      = slv_b_ready_o;
      seen    = mst_b_valid_o;
      seen_id = mst_b_id_o;
      @(posedge clk_i);
      n++;
      if (!hs && n >= TIMEOUT) begin
        report_timeout("B ready");
        ok = 0;
      end
    end
    slv_b_valid_i <= 1'b0;
  endtask

  task automatic run_row(input int i);
    bit           ok;
    bit           got_w;
    bit           seen_b;
    id_t          seen_id;
    int           errs_before;
    fault_cause_e exp;
    addr_t        addr;
    cur_name    = row_name[i];
    errs_before = errors;
    exp         = row_cause[i];
    addr        = 32'h4000_0000 + i * 32'h100 + row_aw_id[i];
    got_w       = 0;
    seen_b      = 0;
    seen_id     = '0;
    @(posedge clk_i);
    guard_ena_i   <= row_ena[i];
    budget_addr_i <= row_bud_a[i];
    budget_data_i <= row_bud_d[i];
    budget_resp_i <= row_bud_r[i];
    irq_cycles  = 0;
    leak_cycles = 0;
    send_aw(row_aw_id[i], addr, row_aw_dly[i], ok);
    if (ok) send_w(row_w_dly[i], ok, got_w);
    // Slave only responds to a write it actually received
    if (ok && got_w) send_b(row_b_id[i], row_b_dly[i], ok, seen_b, seen_id);
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    compare("reset_req_o", exp != FAULT_NONE, reset_req_o);
    compare("fault_cause_o", exp, fault_cause_o);
    compare("irq_o cycles", (exp != FAULT_NONE) ? 1 : 0, irq_cycles);
    compare("valids while blocked", 0, leak_cycles);
    if (exp == FAULT_ID_MISMATCH) begin
      compare("fault_id_o", row_b_id[i], fault_id_o);
    end else if (exp != FAULT_NONE) begin
      compare("fault_id_o", row_aw_id[i], fault_id_o);
      compare("fault_addr_o", addr, fault_addr_o);
    end else begin
      compare("B seen by master", 1, seen_b);
      compare("B ID", row_aw_id[i], seen_id);
    end
    @(posedge clk_i);
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
    @(negedge clk_i);
    compare("reset_req_o after clear", 0, reset_req_o);
    tests++;
    $display("Test %-14s %s", cur_name, (errors == errs_before) ? "passed" : "FAILED");
  endtask

  // Four writes stuck before W fill the table, a fifth AW must wait
  task automatic check_table_full();
    bit  ok;
    bit  got_w;
    bit  seen_b;
    id_t seen_id;
    int  n;
    bit  hs;
    int  errs_before;
    cur_name    = "table_full";
    errs_before = errors;
    ok          = 1;
    hs          = 0;
    n           = 0;
    @(posedge clk_i);
    guard_ena_i   <= 1'b1;
    budget_addr_i <= 8'd250;
    budget_data_i <= 8'd250;
    budget_resp_i <= 8'd250;
    for (int k = 0; k < 4; k++) begin
      if (ok) send_aw(id_t'(k + 1), 32'h5000_0000 + k * 16, 0, ok);
    end
    @(posedge clk_i);
    mst_aw_valid_i <= 1'b1;
    mst_aw_id_i    <= 4'd5;
    mst_aw_addr_i  <= 32'h5000_0040;
    slv_aw_ready_i <= 1'b1;
    early_aw = 0;
    aw_watch = 1;
    if (ok) send_w(0, ok, got_w);
    if (ok) send_b(4'd1, 2, ok, seen_b, seen_id);
    aw_watch = 0;
    while (!hs && ok) begin
      @(negedge clk_i);
      hs = mst_aw_ready_o;
      @(posedge clk_i);
      n++;
      if (!hs && n >= TIMEOUT) begin
        report_timeout("the fifth AW");
        ok = 0;
      end
    end
    mst_aw_valid_i <= 1'b0;
    slv_aw_ready_i <= 1'b0;
    compare("AW ready while full", 0, early_aw);
    compare("W seen by slave", 1, got_w);
    compare("B seen by master", 1, seen_b);
    compare("B ID", 1, seen_id);
    compare("reset_req_o", 0, reset_req_o);
    // Disabling the guard empties the slot table
    @(posedge clk_i);
    guard_ena_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    guard_ena_i <= 1'b1;
    tests++;
    $display("Test %-14s %s", cur_name, (errors == errs_before) ? "passed" : "FAILED");
  endtask

  initial begin
    rst_ni         = 1'b0;
    guard_ena_i    = 1'b1;
    clear_i        = 1'b0;
    budget_addr_i  = 8'd8;
    budget_data_i  = 8'd8;
    budget_resp_i  = 8'd8;
    mst_aw_valid_i = 1'b0;
    mst_aw_id_i    = '0;
    mst_aw_addr_i  = '0;
    mst_w_valid_i  = 1'b0;
    mst_w_last_i   = 1'b0;
    mst_b_ready_i  = 1'b1;
    slv_aw_ready_i = 1'b0;
    slv_w_ready_i  = 1'b1;
    slv_b_valid_i  = 1'b0;
    slv_b_id_i     = '0;
    void'($urandom(32'haeaaa22d));
    fill_table();
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
      repeat ($urandom_range(4, 1)) @(posedge clk_i);
    end
    check_table_full();
    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== write_guard.f ====
+incdir+logic
logic/wg_pkg.sv
logic/wg_event_if.sv
logic/wg_status_if.sv
logic/wg_decode.sv
logic/wg_execute.sv
logic/wg_result.sv
logic/write_guard.sv
sim/tb_write_guard.sv
